// ==== build.f ====
+incdir+.
csr_pkg.sv
excp_pkg.sv
csr_exc_regs.sv
csr_timer.sv
csr_scratch.sv
csr_read_mux.sv
csr_top.sv
tb_csr_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
TOP       = tb_csr_top
RTL_TOP   = csr_top
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_csr_top.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr_top;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES   = 2000;   // Tests take about 220 cycles

    logic                 clk;
    logic                 rst;
    csr_pkg::csr_write_t  wr;
    csr_pkg::csr_addr_t   rd_addr;
    csr_pkg::csr_data_t   rd_data;
    csr_pkg::hwi_t        hwi;
    excp_pkg::exc_event_t exc;
    excp_pkg::trap_ctrl_t trap;
    logic [31:0]          lcg_state;
    int                   cycle_cnt = 0;

    csr_top i_dut (
        .clk(clk), .rst(rst), .wr(wr), .rd_addr(rd_addr), .rd_data(rd_data),
        .hwi(hwi), .exc(exc), .trap(trap)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Errors found");
            $fatal(1, "Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_data(input string test, input csr_pkg::csr_data_t expected,
                              input csr_pkg::csr_data_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", test, expected, actual);
            $display("Errors found");
            $fatal(1, "Stopped at the first wrong value");
        end
    endtask

    task automatic check_bit(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %b, actual %b", test, expected, actual);
            $display("Errors found");
            $fatal(1, "Stopped at the first wrong value");
        end
    endtask

    // One-cycle write, returns at the falling edge after the write edge
    task automatic write_csr(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
        @(negedge clk);
        wr.en   = 1'b1;
        wr.addr = addr;
        wr.data = data;
        @(negedge clk);
        wr.en = 1'b0;
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_data_t data);
        rd_addr = addr;
        #1;
        data = rd_data;
    endtask

    task automatic expect_csr(input string test, input csr_pkg::csr_addr_t addr,
                              input csr_pkg::csr_data_t expected);
        csr_pkg::csr_data_t actual;
        read_csr(addr, actual);
        check_data(test, expected, actual);
    endtask

    task automatic pulse_exc(input excp_pkg::exc_event_t ev);
        @(negedge clk);
        exc = ev;
        @(negedge clk);
        exc = '0;
    endtask

    // Polls once per cycle until the masked value matches
    task automatic wait_for_csr(input string test, input csr_pkg::csr_addr_t addr,
                                input csr_pkg::csr_data_t mask,
                                input csr_pkg::csr_data_t value, input int max_cycles);
        csr_pkg::csr_data_t data;
        int waited = 0;
        read_csr(addr, data);
        while ((data & mask) != value) begin
            if (waited == max_cycles) begin
                $display("Errors found");
                $fatal(1, "%s: CSR %h did not reach %h within %0d cycles",
                       test, addr, value, max_cycles);
            end else begin
                @(negedge clk);
                waited++;
                read_csr(addr, data);
            end
        end
    endtask

    task automatic reset_values();
        expect_csr("reset crmd", `CSR_CRMD, 32'h8);
        expect_csr("reset prmd", `CSR_PRMD, '0);
        expect_csr("reset estat", `CSR_ESTAT, '0);
        expect_csr("reset era", `CSR_ERA, '0);
        expect_csr("reset tval", `CSR_TVAL, '0);
        expect_csr("reset save0", `CSR_SAVE0, '0);
        expect_csr("reset unmapped", 14'h0123, '0);
        check_data("reset trap crmd", 32'h8, trap.crmd);
        check_bit("reset interrupt", 1'b0, trap.interrupt);
    endtask

    task automatic write_masking();
        csr_pkg::csr_addr_t save_addr [4];
        csr_pkg::csr_data_t save_val [4];
        csr_pkg::csr_data_t v;
        save_addr = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3};
        for (int i = 0; i < 4; i++) begin
            save_val[i] = next_rand();
            write_csr(save_addr[i], save_val[i]);
        end
        for (int i = 0; i < 4; i++)
            expect_csr("save readback", save_addr[i], save_val[i]);
        v = next_rand();
        write_csr(`CSR_TID, v);
        expect_csr("tid readback", `CSR_TID, v);
        v = next_rand();
        write_csr(`CSR_EENTRY, v);
        expect_csr("eentry align", `CSR_EENTRY, {v[31:6], 6'b0});
        check_data("eentry trap", {v[31:6], 6'b0}, trap.eentry);
        v = next_rand();
        write_csr(`CSR_PRMD, v);
        expect_csr("prmd mask", `CSR_PRMD, {29'b0, v[2:0]});   // PIE and PPLV only
        write_csr(`CSR_TICLR, next_rand());
        expect_csr("ticlr read", `CSR_TICLR, '0);
    endtask

    task automatic exception_return();
        excp_pkg::exc_event_t ev;
        csr_pkg::csr_data_t   v;
        ev = '0;
        write_csr(`CSR_CRMD, 32'hf);            // DA, IE, PLV 3
        expect_csr("exc setup", `CSR_CRMD, 32'hf);
        v = next_rand();
        ev.exception = 1'b1;
        ev.ecode     = `ECODE_ALE;
        ev.pc        = v & ~32'h3;
        ev.addr      = next_rand();
        pulse_exc(ev);
        expect_csr("exc crmd", `CSR_CRMD, 32'h8);
        check_data("exc trap crmd", 32'h8, trap.crmd);
        expect_csr("exc prmd", `CSR_PRMD, 32'h7);
        expect_csr("exc era", `CSR_ERA, ev.pc);
        read_csr(`CSR_ESTAT, v);
        check_data("exc ecode", {26'b0, ev.ecode}, {26'b0, v[21:16]});
        expect_csr("exc badv", `CSR_BADV, ev.addr);
        check_data("exc trap era", ev.pc, trap.era);
        ev      = '0;
        ev.ertn = 1'b1;
        pulse_exc(ev);
        expect_csr("ertn crmd", `CSR_CRMD, 32'hf);
        check_data("ertn trap crmd", 32'hf, trap.crmd);
    endtask

    task automatic interrupt_pending();
        csr_pkg::csr_data_t estat;
        write_csr(`CSR_CRMD, 32'hc);            // PLV 0, IE 1
        write_csr(`CSR_ECFG, 32'h20);           // Hardware line 3 only
        expect_csr("irq ecfg", `CSR_ECFG, 32'h20);
        check_bit("irq idle", 1'b0, trap.interrupt);
        @(negedge clk);
        hwi = 8'h08;
        @(negedge clk);
        check_bit("irq hwi3", 1'b1, trap.interrupt);
        write_csr(`CSR_CRMD, 32'h8);
        check_bit("irq ie off", 1'b0, trap.interrupt);
        write_csr(`CSR_CRMD, 32'hc);
        check_bit("irq ie on", 1'b1, trap.interrupt);
        @(negedge clk);
        hwi = 8'h10;                            // Line 4, masked
        repeat (4) begin
            @(negedge clk);
            check_bit("irq masked", 1'b0, trap.interrupt);
        end
        read_csr(`CSR_ESTAT, estat);
        check_data("irq masked pending", 32'h40, estat & 32'h3fc);
        @(negedge clk);
        hwi = '0;
        write_csr(`CSR_ECFG, '0);
    endtask

    task automatic one_shot_timer();
        csr_pkg::csr_data_t estat;
        int n = 40;
        write_csr(`CSR_ECFG, 32'h800);          // Timer line
        write_csr(`CSR_TCFG, 32'(n) | 32'h1);
        for (int k = 1; k <= n + 2; k++) begin
            @(negedge clk);
            read_csr(`CSR_ESTAT, estat);
            check_bit("oneshot ti", k == n + 2, estat[11]);
            check_bit("oneshot irq", k == n + 2, trap.interrupt);
        end
        write_csr(`CSR_TICLR, 32'h1);
        read_csr(`CSR_ESTAT, estat);
        check_bit("oneshot ticlr", 1'b0, estat[11]);
        expect_csr("oneshot tval", `CSR_TVAL, '1);
        repeat (2 * n) begin
            @(negedge clk);
            read_csr(`CSR_ESTAT, estat);
            check_bit("oneshot no refire", 1'b0, estat[11]);
        end
    endtask

    task automatic periodic_timer();
        csr_pkg::csr_data_t estat;
        int n = 12;
        write_csr(`CSR_TCFG, 32'(n) | 32'h3);
        expect_csr("periodic tcfg", `CSR_TCFG, 32'(n) | 32'h3);
        wait_for_csr("periodic first", `CSR_ESTAT, 32'h800, 32'h800, 2 * n);
        write_csr(`CSR_TICLR, 32'h1);
        read_csr(`CSR_ESTAT, estat);
        check_bit("periodic ticlr", 1'b0, estat[11]);
        wait_for_csr("periodic zero", `CSR_TVAL, '1, '0, 2 * n);
        @(negedge clk);
        expect_csr("periodic reload", `CSR_TVAL, 32'(n));
        wait_for_csr("periodic again", `CSR_ESTAT, 32'h800, 32'h800, 2 * n);
        write_csr(`CSR_TCFG, '0);
        write_csr(`CSR_TICLR, 32'h1);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        wr        = '0;
        rd_addr   = '0;
        hwi       = '0;
        exc       = '0;
        lcg_state = 32'd47;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_values();
        write_masking();
        exception_return();
        interrupt_pending();
        one_shot_timer();
        periodic_timer();
        $display("No errors");
        $finish;
    end

endmodule

// ==== csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_write_t  wr,
    input  csr_pkg::csr_addr_t   rd_addr,
    output csr_pkg::csr_data_t   rd_data,
    input  csr_pkg::hwi_t        hwi,
    input  excp_pkg::exc_event_t exc,
    output excp_pkg::trap_ctrl_t trap
);

    csr_pkg::csr_data_t crmd, prmd, ecfg, estat, era, badv, eentry;
    csr_pkg::csr_data_t tid, tcfg, tval;
    csr_pkg::csr_data_t save0, save1, save2, save3;
    logic               timer_fire;
    logic               interrupt;

    csr_exc_regs i_exc_regs (
        .clk(clk), .rst(rst), .wr(wr), .exc(exc), .hwi(hwi),
        .timer_fire(timer_fire),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat),
        .era(era), .badv(badv), .eentry(eentry),
        .interrupt(interrupt)
    );

    csr_timer i_timer (
        .clk(clk), .rst(rst), .wr(wr),
        .tid(tid), .tcfg(tcfg), .tval(tval),
        .timer_fire(timer_fire)
    );

    csr_scratch i_scratch (
        .clk(clk), .rst(rst), .wr(wr),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3)
    );

    csr_read_mux i_read_mux (
        .rd_addr(rd_addr),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat),
        .era(era), .badv(badv), .eentry(eentry),
        .tid(tid), .tcfg(tcfg), .tval(tval),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .rd_data(rd_data)
    );

    assign trap.crmd      = crmd;
    assign trap.era       = era;
    assign trap.eentry    = eentry;
    assign trap.interrupt = interrupt;

endmodule

// ==== csr_read_mux.sv ====
`include "csr_settings.svh"
`timescale 1ns/1ps

module csr_read_mux (
    input  csr_pkg::csr_addr_t rd_addr,
    input  csr_pkg::csr_data_t crmd,
    input  csr_pkg::csr_data_t prmd,
    input  csr_pkg::csr_data_t ecfg,
    input  csr_pkg::csr_data_t estat,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t badv,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t tid,
    input  csr_pkg::csr_data_t tcfg,
    input  csr_pkg::csr_data_t tval,
    input  csr_pkg::csr_data_t save0,
    input  csr_pkg::csr_data_t save1,
    input  csr_pkg::csr_data_t save2,
    input  csr_pkg::csr_data_t save3,
    output csr_pkg::csr_data_t rd_data
);

    always_comb begin
        case (rd_addr)
            `CSR_CRMD:   rd_data = crmd;
            `CSR_PRMD:   rd_data = prmd;
            `CSR_ECFG:   rd_data = ecfg;
            `CSR_ESTAT:  rd_data = estat;
            `CSR_ERA:    rd_data = era;
            `CSR_BADV:   rd_data = badv;
            `CSR_EENTRY: rd_data = eentry;
            `CSR_SAVE0:  rd_data = save0;
            `CSR_SAVE1:  rd_data = save1;
            `CSR_SAVE2:  rd_data = save2;
            `CSR_SAVE3:  rd_data = save3;
            `CSR_TID:    rd_data = tid;
            `CSR_TCFG:   rd_data = tcfg;
            `CSR_TVAL:   rd_data = tval;
            `CSR_TICLR:  rd_data = '0;    // Write-only clear
            default:     rd_data = '0;
        endcase
    end

endmodule

// ==== csr_scratch.sv ====
`include "csr_settings.svh"
`timescale 1ns/1ps

module csr_scratch (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_write_t wr,
    output csr_pkg::csr_data_t  save0,
    output csr_pkg::csr_data_t  save1,
    output csr_pkg::csr_data_t  save2,
    output csr_pkg::csr_data_t  save3
);

    csr_pkg::csr_data_t save_q [4];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst)
                save_q[i] <= '0;
            else if (wr.en && (wr.addr == csr_pkg::csr_addr_t'(`CSR_SAVE0 + i)))
                save_q[i] <= wr.data;   // SAVEn are consecutive
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// ==== csr_timer.sv ====
`include "csr_settings.svh"
`timescale 1ns/1ps

module csr_timer (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_write_t wr,
    output csr_pkg::csr_data_t  tid,
    output csr_pkg::csr_data_t  tcfg,
    output csr_pkg::csr_data_t  tval,
    output logic                timer_fire
);

    csr_pkg::timer_state_t state;
    csr_pkg::csr_data_t    init_val;
    logic                  tid_we;
    logic                  tcfg_we;

    assign tid_we   = wr.en && (wr.addr == `CSR_TID);
    assign tcfg_we  = wr.en && (wr.addr == `CSR_TCFG);
    assign init_val = {tcfg[31:2], 2'b00};

    always_ff @(posedge clk) begin
        if (rst)
            tid <= '0;
        else if (tid_we)
            tid <= wr.data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= csr_pkg::TIMER_IDLE;
            tcfg       <= '0;
            tval       <= '0;
            timer_fire <= 1'b0;
        end else begin
            timer_fire <= 1'b0;
            if (tcfg_we) begin
                tcfg  <= wr.data;
                tval  <= {wr.data[31:2], 2'b00};
                state <= wr.data[`TCFG_EN_BIT] ? csr_pkg::TIMER_RUN : csr_pkg::TIMER_IDLE;
            end else if (state == csr_pkg::TIMER_RUN) begin
                if (tval != '0) begin
                    tval <= tval - 32'd1;
                end else begin
                    timer_fire <= 1'b1;
                    if (tcfg[`TCFG_PERIODIC_BIT]) begin
                        tval <= init_val;            // Periodic reload
                    end else begin
                        tval  <= '1;
                        state <= csr_pkg::TIMER_IDLE;
                    end
                end
            end
        end
    end

    // Pulse lands one edge after the countdown hit zero while running
    a_fire_in_run: assert property (@(posedge clk) disable iff (rst)
        timer_fire |-> $past(state == csr_pkg::TIMER_RUN));

endmodule

// ==== csr_exc_regs.sv ====
`include "csr_settings.svh"
`timescale 1ns/1ps

module csr_exc_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_write_t  wr,
    input  excp_pkg::exc_event_t exc,
    input  csr_pkg::hwi_t        hwi,
    input  logic                 timer_fire,
    output csr_pkg::csr_data_t   crmd,
    output csr_pkg::csr_data_t   prmd,
    output csr_pkg::csr_data_t   ecfg,
    output csr_pkg::csr_data_t   estat,
    output csr_pkg::csr_data_t   era,
    output csr_pkg::csr_data_t   badv,
    output csr_pkg::csr_data_t   eentry,
    output logic                 interrupt
);

    logic crmd_we, prmd_we, ecfg_we, estat_we, era_we, badv_we, eentry_we;
    logic ticlr_clr;
    logic addr_fault;

    function automatic csr_pkg::csr_data_t merge(input csr_pkg::csr_data_t old_val,
                                                 input csr_pkg::csr_data_t new_val,
                                                 input csr_pkg::csr_data_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    assign crmd_we   = wr.en && (wr.addr == `CSR_CRMD);
    assign prmd_we   = wr.en && (wr.addr == `CSR_PRMD);
    assign ecfg_we   = wr.en && (wr.addr == `CSR_ECFG);
    assign estat_we  = wr.en && (wr.addr == `CSR_ESTAT);
    assign era_we    = wr.en && (wr.addr == `CSR_ERA);
    assign badv_we   = wr.en && (wr.addr == `CSR_BADV);
    assign eentry_we = wr.en && (wr.addr == `CSR_EENTRY);
    assign ticlr_clr = wr.en && (wr.addr == `CSR_TICLR) && wr.data[`TICLR_CLR_BIT];

    assign addr_fault = exc.ecode inside {`ECODE_ADEF, `ECODE_ALE, `ECODE_PIL, `ECODE_PIS,
                                          `ECODE_PIF, `ECODE_PME, `ECODE_PPI};

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= `CRMD_RESET;
            prmd <= '0;
        end else if (exc.exception) begin
            crmd[`CRMD_IE_BIT:0] <= '0;              // Kernel, interrupts off
            prmd[`CRMD_IE_BIT:0] <= crmd[`CRMD_IE_BIT:0];
        end else if (exc.ertn) begin
            crmd[`CRMD_IE_BIT:0] <= prmd[`CRMD_IE_BIT:0];
        end else begin
            if (crmd_we)
                crmd <= merge(crmd, wr.data, `CRMD_WMASK);
            if (prmd_we)
                prmd <= merge(prmd, wr.data, `PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg   <= '0;
            eentry <= '0;
        end else begin
            if (ecfg_we)
                ecfg <= merge(ecfg, wr.data, `ECFG_LIE_MASK);
            if (eentry_we)
                eentry <= merge(eentry, wr.data, `EENTRY_ALIGN_MASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat <= '0;
        end else begin
            estat[`ESTAT_HWI_LSB +: 8] <= hwi;
            if (ticlr_clr)
                estat[`ESTAT_TI_BIT] <= 1'b0;    // Clear beats a new fire
            else if (timer_fire)
                estat[`ESTAT_TI_BIT] <= 1'b1;
            if (exc.exception) begin
                estat[`ESTAT_ECODE_LSB +: 6] <= exc.ecode;
                estat[`ESTAT_ESUB_LSB +: 9]  <= exc.esubcode;
            end else if (estat_we) begin
                estat[`ESTAT_SW_MSB:0] <= wr.data[`ESTAT_SW_MSB:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era  <= '0;
            badv <= '0;
        end else if (exc.exception) begin
            era <= exc.pc;
            if (addr_fault)
                badv <= exc.inst_fault ? exc.pc : exc.addr;
        end else begin
            if (era_we)
                era <= wr.data;
            if (badv_we)
                badv <= wr.data;
        end
    end

    assign interrupt = ((ecfg & estat & `ECFG_LIE_MASK) != '0) && crmd[`CRMD_IE_BIT];

    a_exc_ertn_excl: assert property (@(posedge clk) disable iff (rst)
        !(exc.exception && exc.ertn));

    a_ecode_stable: assert property (@(posedge clk) disable iff (rst)
        !exc.exception |=> $stable(estat[`ESTAT_ECODE_LSB +: 6]));

endmodule

// ==== excp_pkg.sv ====
package excp_pkg;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    // Commit-point event, valid for one cycle
    typedef struct packed {
        logic              exception;
        logic              ertn;
        ecode_t            ecode;
        esubcode_t         esubcode;
        csr_pkg::csr_data_t pc;
        csr_pkg::csr_data_t addr;   // Faulting data address
        logic              inst_fault;
    } exc_event_t;

    // Back to the pipeline
    typedef struct packed {
        csr_pkg::csr_data_t crmd;
        csr_pkg::csr_data_t era;
        csr_pkg::csr_data_t eentry;
        logic              interrupt;
    } trap_ctrl_t;

endpackage

// ==== csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] csr_data_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [7:0]  hwi_t;

    // Register write from the write-back stage
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_write_t;

    typedef enum logic {
        TIMER_IDLE,
        TIMER_RUN
    } timer_state_t;

endpackage

// ==== csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// CSR numbers
`define CSR_CRMD    14'h0000
`define CSR_PRMD    14'h0001
`define CSR_ECFG    14'h0004
`define CSR_ESTAT   14'h0005
`define CSR_ERA     14'h0006
`define CSR_BADV    14'h0007
`define CSR_EENTRY  14'h000c
`define CSR_SAVE0   14'h0030
`define CSR_SAVE1   14'h0031
`define CSR_SAVE2   14'h0032
`define CSR_SAVE3   14'h0033
`define CSR_TID     14'h0040
`define CSR_TCFG    14'h0041
`define CSR_TVAL    14'h0042
`define CSR_TICLR   14'h0044

`define CRMD_RESET        32'h0000_0008  // DA=1, IE=0, PLV=0
`define CRMD_WMASK        32'h0000_01ff
`define CRMD_IE_BIT       2
`define PRMD_WMASK        32'h0000_0007
`define ECFG_LIE_MASK     32'h0000_1bff  // Bit 10 reserved
`define ESTAT_SW_MSB      1
`define ESTAT_HWI_LSB     2
`define ESTAT_TI_BIT      11
`define ESTAT_ECODE_LSB   16
`define ESTAT_ESUB_LSB    22
`define EENTRY_ALIGN_MASK 32'hffff_ffc0
`define TCFG_EN_BIT       0
`define TCFG_PERIODIC_BIT 1
`define TICLR_CLR_BIT     0

// Exception codes that load BADV
`define ECODE_PIL   6'h01
`define ECODE_PIS   6'h02
`define ECODE_PIF   6'h03
`define ECODE_PME   6'h04
`define ECODE_PPI   6'h07
`define ECODE_ADEF  6'h08
`define ECODE_ALE   6'h09

`endif
